/* design/mem_req_pkg.sv */
// shared types for the request path; word addressed, 256 x 32-bit, no byte selects
package mem_req_pkg;

    // word address into the sram, 256 words
    typedef logic [7:0] addr_t;

    // one full data word
    typedef logic [31:0] data_t;

    // one client request as it sits in a queue
    // 41 bits: write flag, address, write data
    typedef struct packed {
        logic  we;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    // wishbone classic, master to slave
    // no sel, no cti/bte, no lock
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        data_t dat_w;
    } wb_m2s_t;

    // wishbone classic, slave to master
    // no err or rty, the slave always completes
    typedef struct packed {
        logic  ack;
        data_t dat_r;
    } wb_s2m_t;

endpackage

/* design/binary_occupancy.sv */
// occupancy tracker only; caller must never push when full or pop when empty
`timescale 1ns/100ps

module binary_occupancy #(
    parameter int DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic pop,
    output logic valid,
    output logic empty,
    output logic full
);

    // one extra bit so a count of DEPTH fits
    localparam int CNT_W = $clog2(DEPTH) + 1;

    logic [CNT_W-1:0] count;

    // entry count
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // valid and full follow the count on the same edge
    // push and pop together leave both alone
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            full  <= 1'b0;
        end else begin
            case ({push, pop})
                2'b10: begin
                    valid <= 1'b1;
                    // last free slot being taken
                    full  <= (count == CNT_W'(DEPTH - 1));
                end
                2'b01: begin
                    // last entry leaving
                    valid <= !(count == CNT_W'(1));
                    full  <= 1'b0;
                end
                default: begin
                    valid <= valid;
                    full  <= full;
                end
            endcase
        end
    end

    assign empty = ~valid;

endmodule

/* design/req_fifo.sv */
// request queue; FIFO_DEPTH must be a power of two and at least 2, push must be gated by full
`timescale 1ns/100ps

module req_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  mem_req_pkg::mem_req_t push_req,
    input  logic                 pop,
    output mem_req_pkg::mem_req_t head,
    output logic                 head_valid,
    output logic                 full
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // request storage, no reset needed
    mem_req_pkg::mem_req_t entries [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // write the new request into the slot at the tail
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_req;
        end
    end

    // head is visible the cycle after its push
    assign head = entries[rd_ptr];

    // occupancy gives head_valid and full, empty is just ~head_valid
    binary_occupancy #(
        .DEPTH (FIFO_DEPTH)
    ) u_binary_occupancy (
        .clk   (clk),
        .rst   (rst),
        .push  (push),
        .pop   (pop),
        .valid (head_valid),
        .empty (),
        .full  (full)
    );

endmodule

/* design/rr_arbiter.sv */
// round-robin arbiter; grant is combinational, advance must only come with a valid grant
`timescale 1ns/100ps

module rr_arbiter #(
    parameter int NUM_PORTS = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [NUM_PORTS-1:0]         valid,
    input  logic                         advance,
    output logic [NUM_PORTS-1:0]         grant,
    output logic [$clog2(NUM_PORTS)-1:0] grant_idx
);

    localparam int IDX_W = $clog2(NUM_PORTS);

    // client with highest priority this cycle
    logic [IDX_W-1:0] ptr;
    logic             found;

    // walk from ptr, first valid client wins
    always_comb begin
        int cand;
        grant     = '0;
        grant_idx = '0;
        found     = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            cand = int'(ptr) + i;
            // modulo for non power of two port counts
            if (cand >= NUM_PORTS) begin
                cand = cand - NUM_PORTS;
            end
            if (!found && valid[cand]) begin
                found       = 1'b1;
                grant[cand] = 1'b1;
                grant_idx   = IDX_W'(cand);
            end
        end
    end

    // winner drops to lowest priority once served
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (advance && found) begin
            if (grant_idx == IDX_W'(NUM_PORTS - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= grant_idx + 1'b1;
            end
        end
    end

endmodule

/* design/wb_master.sv */
// single-outstanding wishbone classic master; reads answer for one cycle, writes are silent
`timescale 1ns/100ps

module wb_master #(
    parameter int NUM_PORTS = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  mem_req_pkg::mem_req_t        head [NUM_PORTS],
    input  logic                         any_valid,
    input  logic [$clog2(NUM_PORTS)-1:0] grant_idx,
    output logic                         take,
    output mem_req_pkg::wb_m2s_t         wb_o,
    input  mem_req_pkg::wb_s2m_t         wb_i,
    output logic [NUM_PORTS-1:0]         rsp_valid,
    output mem_req_pkg::data_t           rsp_data
);

    localparam int IDX_W = $clog2(NUM_PORTS);

    // BUS holds cyc/stb, DONE is the response cycle with the bus released
    typedef enum logic [1:0] {
        IDLE,
        BUS,
        DONE
    } state_t;

    state_t state;

    // request in flight and who asked for it
    mem_req_pkg::mem_req_t cur_req;
    logic [IDX_W-1:0]      cur_idx;

    // DONE can take the next request straight away
    assign take = (state != BUS) && any_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (take) state <= BUS;
                BUS:  if (wb_i.ack) state <= DONE;
                DONE: state <= take ? BUS : IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // latch the granted head on the take edge
    always_ff @(posedge clk) begin
        if (take) begin
            cur_req <= head[grant_idx];
            cur_idx <= grant_idx;
        end
    end

    // adr, we and dat_w stay put until ack
    assign wb_o.cyc   = (state == BUS);
    assign wb_o.stb   = (state == BUS);
    assign wb_o.we    = cur_req.we;
    assign wb_o.adr   = cur_req.addr;
    assign wb_o.dat_w = cur_req.wdata;

    // one-cycle pulse to the issuing client only
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= '0;
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                rsp_valid[i] <= (state == BUS) && wb_i.ack && !cur_req.we &&
                                (cur_idx == IDX_W'(i));
            end
        end
    end

    // read data captured with ack, shared by all clients
    always_ff @(posedge clk) begin
        if ((state == BUS) && wb_i.ack) begin
            rsp_data <= wb_i.dat_r;
        end
    end

endmodule

/* design/wb_sram.sv */
// wishbone classic sram slave; one wait state, full-word access only, contents not reset
`timescale 1ns/100ps

module wb_sram (
    input  logic                 clk,
    input  logic                 rst,
    input  mem_req_pkg::wb_m2s_t wb_i,
    output mem_req_pkg::wb_s2m_t wb_o
);

    localparam int WORDS = 2 ** $bits(mem_req_pkg::addr_t);

    mem_req_pkg::data_t mem [WORDS];

    logic               ack;
    mem_req_pkg::data_t dat_r;
    logic               req;

    assign req = wb_i.cyc && wb_i.stb;

    // ack one cycle after stb first seen, then drop
    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= req && !ack;
        end
    end

    // write lands on the acked edge, master still holds dat_w
    always_ff @(posedge clk) begin
        if (req && ack && wb_i.we) begin
            mem[wb_i.adr] <= wb_i.dat_w;
        end
    end

    // read word fetched in the wait state, ready with ack
    always_ff @(posedge clk) begin
        if (req && !ack) begin
            dat_r <= mem[wb_i.adr];
        end
    end

    assign wb_o.ack   = ack;
    assign wb_o.dat_r = dat_r;

endmodule

/* design/mem_req_top.sv */
// two-client request path to one sram; responses cannot stall, order kept per client only
`timescale 1ns/100ps

module mem_req_top #(
    parameter int NUM_PORTS  = 2,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_req_pkg::mem_req_t req [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]  req_valid,
    output logic [NUM_PORTS-1:0]  req_ready,
    output logic [NUM_PORTS-1:0]  rsp_valid,
    output mem_req_pkg::data_t    rsp_data
);

    localparam int IDX_W = $clog2(NUM_PORTS);

    // queue heads toward the master
    mem_req_pkg::mem_req_t head [NUM_PORTS];
    logic [NUM_PORTS-1:0]  head_valid;
    logic [NUM_PORTS-1:0]  full;
    logic [NUM_PORTS-1:0]  push;
    logic [NUM_PORTS-1:0]  pop;

    // arbitration
    logic [NUM_PORTS-1:0]  grant;
    logic [IDX_W-1:0]      grant_idx;
    logic                  take;
    logic                  any_valid;

    // bus between master and sram
    mem_req_pkg::wb_m2s_t  wb_m2s;
    mem_req_pkg::wb_s2m_t  wb_s2m;

    assign any_valid = |head_valid;

    // one queue per client
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_client
        assign req_ready[i] = ~full[i];
        // accepted on valid and ready together
        assign push[i]      = req_valid[i] & req_ready[i];
        // only the granted queue pops
        assign pop[i]       = take & grant[i];

        req_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_req_fifo (
            .clk        (clk),
            .rst        (rst),
            .push       (push[i]),
            .push_req   (req[i]),
            .pop        (pop[i]),
            .head       (head[i]),
            .head_valid (head_valid[i]),
            .full       (full[i])
        );
    end

    // take doubles as the arbiter advance
    rr_arbiter #(
        .NUM_PORTS (NUM_PORTS)
    ) u_rr_arbiter (
        .clk       (clk),
        .rst       (rst),
        .valid     (head_valid),
        .advance   (take),
        .grant     (grant),
        .grant_idx (grant_idx)
    );

    wb_master #(
        .NUM_PORTS (NUM_PORTS)
    ) u_wb_master (
        .clk       (clk),
        .rst       (rst),
        .head      (head),
        .any_valid (any_valid),
        .grant_idx (grant_idx),
        .take      (take),
        .wb_o      (wb_m2s),
        .wb_i      (wb_s2m),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

    wb_sram u_wb_sram (
        .clk  (clk),
        .rst  (rst),
        .wb_i (wb_m2s),
        .wb_o (wb_s2m)
    );

endmodule

/* tb/tb_mem_req_top.sv */
// testbench for mem_req_top at default parameters; sram holds X until written, so reads follow writes
`timescale 1ns/100ps

module tb_mem_req_top;

    localparam int NUM_RANDOM = 300;
    // bus bound at 3 cycles per transfer, doubled for random gaps, plus reset
    localparam int TIMEOUT_CYCLES = 16 + 2 * 3 * (2 * NUM_RANDOM + 64);

    logic                  clk;
    logic                  rst;
    mem_req_pkg::mem_req_t req [2];
    logic [1:0]            req_valid;
    logic [1:0]            req_ready;
    logic [1:0]            rsp_valid;
    mem_req_pkg::data_t    rsp_data;

    // reference memory and per-client expected read data
    mem_req_pkg::data_t ref_mem [256];
    bit                 issued_wr [256];
    mem_req_pkg::data_t exp_q0 [$];
    mem_req_pkg::data_t exp_q1 [$];
    int                 rd_cnt [2];
    int                 rsp_cnt [2];
    int                 errors;
    int                 cycles;
    int                 seed;
    int                 lat;
    int                 base;
    bit                 ready_dropped;

    mem_req_top u_mem_req_top (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

    always #50 clk = ~clk;

    // a read returns the last word written to its address
    function automatic mem_req_pkg::data_t expected_read(input mem_req_pkg::addr_t a);
        return ref_mem[a];
    endfunction

    // model update on every accepted request
    always @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 2; i++) begin
                if (req_valid[i] && req_ready[i]) begin
                    if (req[i].we) begin
                        ref_mem[req[i].addr] = req[i].wdata;
                    end else begin
                        rd_cnt[i]++;
                        if (i == 0) begin
                            exp_q0.push_back(expected_read(req[i].addr));
                        end else begin
                            exp_q1.push_back(expected_read(req[i].addr));
                        end
                    end
                end
            end
            // client 0 held off by a full queue
            if (req_valid[0] && !req_ready[0]) begin
                ready_dropped = 1'b1;
            end
        end
    end

    // response checker, one expected word per pulse
    always @(posedge clk) begin
        mem_req_pkg::data_t want;
        if (!rst) begin
            if (rsp_valid[0] && rsp_valid[1]) begin
                $display("Error at %0t: rsp_valid pulsed for both clients at once", $time);
                errors++;
            end
            for (int i = 0; i < 2; i++) begin
                if (rsp_valid[i]) begin
                    rsp_cnt[i]++;
                    if ((i == 0) ? (exp_q0.size() == 0) : (exp_q1.size() == 0)) begin
                        $display("Error at %0t: response on client %0d with no read outstanding",
                                 $time, i);
                        errors++;
                    end else begin
                        want = (i == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
                        if (rsp_data !== want) begin
                            $display("Mismatch at %0t: rsp_data client %0d expected %h got %h",
                                     $time, i, want, rsp_data);
                            errors++;
                        end
                    end
                end
            end
        end
    end

    // hard stop
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Error: run still busy after %0d cycles", cycles);
            $display("errors: %0d", errors + 1);
            $display("Test failed");
            $finish;
        end
    end

    // hold request until accepted, returns on the accepting edge
    task automatic send_req(input int c, input logic we, input mem_req_pkg::addr_t a,
                            input mem_req_pkg::data_t d);
        req[c].we    <= we;
        req[c].addr  <= a;
        req[c].wdata <= d;
        req_valid[c] <= 1'b1;
        if (we) begin
            issued_wr[a] = 1'b1;
        end
        @(posedge clk);
        while (!req_ready[c]) begin
            @(posedge clk);
        end
    endtask

    task automatic idle_client(input int c, input int n);
        req_valid[c] <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    // n writes then n reads of the same words, back to back
    task automatic write_then_read(input int c, input int n);
        for (int k = 0; k < n; k++) begin
            send_req(c, 1'b1, {c[0], 7'(k)}, $random(seed));
        end
        for (int k = 0; k < n; k++) begin
            send_req(c, 1'b0, {c[0], 7'(k)}, '0);
        end
        idle_client(c, 0);
    endtask

    // 16 words per client; a read of a never written word turns into a write
    task automatic random_traffic(input int c);
        mem_req_pkg::addr_t a;
        logic               rd;
        for (int k = 0; k < NUM_RANDOM; k++) begin
            a  = {c[0], 3'b000, 4'($random(seed))};
            rd = $random(seed) & 1;
            if (rd && issued_wr[a]) begin
                send_req(c, 1'b0, a, '0);
            end else begin
                send_req(c, 1'b1, a, $random(seed));
            end
            idle_client(c, $unsigned($random(seed)) % 4);
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        req_valid     = '0;
        req[0]        = '0;
        req[1]        = '0;
        errors        = 0;
        cycles        = 0;
        seed          = 92;
        ready_dropped = 1'b0;
        rd_cnt        = '{0, 0};
        rsp_cnt       = '{0, 0};
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // idle state right after reset
        if (req_ready !== 2'b11) begin
            $display("Mismatch at %0t: req_ready expected 11 got %b", $time, req_ready);
            errors++;
        end
        if (rsp_valid !== 2'b00) begin
            $display("Mismatch at %0t: rsp_valid expected 00 got %b", $time, rsp_valid);
            errors++;
        end

        // lone client: write, then a read on an idle bus
        base = rsp_cnt[0];
        send_req(0, 1'b1, 8'h05, 32'hcafe_0005);
        idle_client(0, 6);
        send_req(0, 1'b0, 8'h05, '0);
        idle_client(0, 0);
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!rsp_valid[0] && lat < 20);
        if (lat != 4) begin
            $display("Mismatch at %0t: read latency expected 4 got %0d", $time, lat);
            errors++;
        end
        idle_client(0, 6);
        if (rsp_cnt[0] - base != 1) begin
            $display("Mismatch at %0t: rsp_valid count client 0 expected 1 got %0d",
                     $time, rsp_cnt[0] - base);
            errors++;
        end

        // both clients at once, then deeper bursts that fill the queues
        fork
            write_then_read(0, 4);
            write_then_read(1, 4);
        join
        // only the deep bursts below may set it
        ready_dropped = 1'b0;
        fork
            write_then_read(0, 8);
            write_then_read(1, 8);
        join
        if (!ready_dropped) begin
            $display("Error at %0t: req_ready for client 0 never dropped under load", $time);
            errors++;
        end

        fork
            random_traffic(0);
            random_traffic(1);
        join

        // drain, then watch for stray pulses
        while (exp_q0.size() + exp_q1.size() != 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        for (int i = 0; i < 2; i++) begin
            if (rd_cnt[i] != rsp_cnt[i]) begin
                $display("Mismatch at %0t: rsp_valid count client %0d expected %0d got %0d",
                         $time, i, rd_cnt[i], rsp_cnt[i]);
                errors++;
            end
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* files.f */
design/mem_req_pkg.sv
design/binary_occupancy.sv
design/req_fifo.sv
design/rr_arbiter.sv
design/wb_master.sv
design/wb_sram.sv
design/mem_req_top.sv
tb/tb_mem_req_top.sv

/* Bender.yml */
package:
  name: mem_req

sources:
  - design/mem_req_pkg.sv
  - design/binary_occupancy.sv
  - design/req_fifo.sv
  - design/rr_arbiter.sv
  - design/wb_master.sv
  - design/wb_sram.sv
  - design/mem_req_top.sv
  - target: test
    files:
      - tb/tb_mem_req_top.sv
